//--- project.f
source/memPkg.sv
source/byteRam.sv
source/memCtrl.sv
source/instFetch.sv
source/instQueue.sv
source/memSubsystem.sv
tests/memSubsystemTb.sv

//--- source/byteRam.sv
module byteRam #(
    parameter int RamAddrBits = 12
) (
    input  logic                   clk,
    input  logic                   we,
    input  logic [RamAddrBits-1:0] addr,
    input  logic [7:0]             wdata,
    output logic [7:0]             rdata
);

    localparam int Depth = 2 ** RamAddrBits;

    logic [7:0] mem [Depth];

    // one write port, registered read of the old contents
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- source/instFetch.sv
module instFetch #(
    parameter memPkg::addrT ResetPc = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetchEnable,
    output logic              fetchReq,
    output memPkg::addrT      fetchAddr,
    input  logic              fetchDone,
    input  memPkg::wordT      fetchInst,
    input  logic              queueFull,
    output logic              pushValid,
    output memPkg::fetchItemT pushItem
);
    import memPkg::*;

    addrT pc;
    logic pending;

    // request stays up with a stable address until done
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= ResetPc;
            pending <= 1'b0;
        end else if (pending) begin
            if (fetchDone) begin
                pending <= 1'b0;
                pc      <= pc + 32'd4;
            end
        end else if (fetchEnable && !queueFull) begin
            pending <= 1'b1;
        end
    end

    assign fetchReq  = pending;
    assign fetchAddr = pc;

    // the done cycle goes straight into the queue
    assign pushValid = pending && fetchDone;
    assign pushItem  = '{pc: pc, inst: fetchInst};

endmodule

//--- source/instQueue.sv
module instQueue #(
    parameter int QueueDepth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pushValid,
    input  memPkg::fetchItemT pushItem,
    input  logic              reserve,
    output logic              full,
    output logic              instValid,
    output memPkg::fetchItemT instItem,
    input  logic              instReady
);
    import memPkg::*;

    localparam int PtrBits   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountBits = $clog2(QueueDepth + 1);

    fetchItemT            entries [QueueDepth];
    logic [PtrBits-1:0]   rdPtr;
    logic [PtrBits-1:0]   wrPtr;
    logic [CountBits-1:0] count;
    logic [CountBits:0]   occupied;
    logic                 reserved;
    logic                 pop;

    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        nextPtr = (ptr == PtrBits'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop       = instValid && instReady;
    assign instValid = (count != '0);
    assign instItem  = entries[rdPtr];

    // an in-flight fetch already owns a slot
    assign occupied = {1'b0, count} + {{CountBits{1'b0}}, reserved};
    assign full     = (occupied >= QueueDepth);

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr    <= '0;
            wrPtr    <= '0;
            count    <= '0;
            reserved <= 1'b0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // held from request start until its word lands
            if (pushValid) begin
                reserved <= 1'b0;
            end else if (reserve) begin
                reserved <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            entries[wrPtr] <= pushItem;
        end
    end

endmodule

//--- source/memCtrl.sv
module memCtrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           dataReq,
    input  memPkg::memReqT dataCmd,
    output logic           dataDone,
    output memPkg::wordT   dataRdata,
    input  logic           fetchReq,
    input  memPkg::addrT   fetchAddr,
    output logic           fetchDone,
    output memPkg::wordT   fetchInst,
    output logic           ramWe,
    output memPkg::addrT   ramAddr,
    output logic [7:0]     ramWdata,
    input  logic [7:0]     ramRdata
);
    import memPkg::*;

    typedef enum logic [1:0] {
        idle,
        readData,
        writeData,
        readInst
    } stateT;

    stateT      state;
    lenT        stage;
    lenT        reqLen;
    addrT       baseAddr;
    wordT       reqData;
    wordT       assembly;
    wordT       merged;
    lenT        offset;
    logic [4:0] byteShift;
    logic       readLast;
    logic       writeLast;
    logic       loadDone;

    // anything but a byte or halfword runs as a full word
    function automatic lenT legalLen(input lenT len);
        case (len)
            LenByte, LenHalf: legalLen = len;
            default:          legalLen = LenWord;
        endcase
    endfunction

    // reads need one extra stage for the ram latency
    assign readLast  = (stage == reqLen);
    assign writeLast = (stage == reqLen - 3'd1);

    // while paused, point back at the byte already read so rdata holds
    assign offset   = rdy ? stage : stage - 3'd1;
    assign ramAddr  = baseAddr + addrT'(offset);
    assign ramWe    = rdy && (state == writeData);
    assign ramWdata = reqData[{stage[1:0], 3'b000} +: 8];

    // byte arriving now belongs to lane stage-1, little endian
    assign byteShift = {stage[1:0] - 2'd1, 3'b000};
    assign merged    = assembly | (wordT'(ramRdata) << byteShift);

    assign loadDone  = rdy && readLast;
    assign dataDone  = rdy && ((state == readData && readLast) ||
                               (state == writeData && writeLast));
    assign dataRdata = (loadDone && state == readData) ? merged : '0;
    assign fetchDone = loadDone && (state == readInst);
    assign fetchInst = fetchDone ? merged : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            stage <= '0;
        end else if (rdy) begin
            case (state)
                idle: begin
                    stage <= '0;
                    // data port wins over fetch
                    if (dataReq) begin
                        state <= dataCmd.isStore ? writeData : readData;
                    end else if (fetchReq) begin
                        state <= readInst;
                    end
                end
                writeData: begin
                    if (writeLast) begin
                        state <= idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    if (readLast) begin
                        state <= idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (state == idle) begin
                assembly <= '0;
                if (dataReq) begin
                    baseAddr <= dataCmd.addr;
                    reqLen   <= legalLen(dataCmd.len);
                    reqData  <= dataCmd.wdata;
                end else begin
                    baseAddr <= fetchAddr;
                    reqLen   <= LenWord;
                    reqData  <= '0;
                end
            end else if (state != writeData && stage != '0) begin
                assembly <= merged;
            end
        end
    end

endmodule

//--- source/memPkg.sv
package memPkg;

    // byte address and data word of the RV32 core
    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;

    // access length in bytes
    typedef logic [2:0] lenT;

    localparam lenT LenByte = 3'd1;
    localparam lenT LenHalf = 3'd2;
    localparam lenT LenWord = 3'd4;

    // data port command, 68 bits
    typedef struct packed {
        logic isStore;
        lenT  len;
        addrT addr;
        wordT wdata;
    } memReqT;

    // one instruction queue entry
    typedef struct packed {
        addrT pc;
        wordT inst;
    } fetchItemT;

endpackage

//--- source/memSubsystem.sv
module memSubsystem #(
    parameter int           RamAddrBits = 12,
    parameter int           QueueDepth  = 4,
    parameter memPkg::addrT ResetPc     = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              fetchEnable,
    input  logic              dataReq,
    input  memPkg::memReqT    dataCmd,
    output logic              dataDone,
    output memPkg::wordT      dataRdata,
    output logic              instValid,
    output memPkg::fetchItemT instItem,
    input  logic              instReady
);
    import memPkg::*;

    logic       fetchReq;
    addrT       fetchAddr;
    logic       fetchDone;
    wordT       fetchInst;
    logic       ramWe;
    addrT       ramAddr;
    logic [7:0] ramWdata;
    logic [7:0] ramRdata;
    logic       queueFull;
    logic       pushValid;
    fetchItemT  pushItem;

    byteRam #(
        .RamAddrBits(RamAddrBits)
    ) ram (
        .clk  (clk),
        .we   (ramWe),
        .addr (ramAddr[RamAddrBits-1:0]),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

    memCtrl ctrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .dataReq  (dataReq),
        .dataCmd  (dataCmd),
        .dataDone (dataDone),
        .dataRdata(dataRdata),
        .fetchReq (fetchReq),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    instFetch #(
        .ResetPc(ResetPc)
    ) fetch (
        .clk        (clk),
        .rst        (rst),
        .fetchEnable(fetchEnable),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .queueFull  (queueFull),
        .pushValid  (pushValid),
        .pushItem   (pushItem)
    );

    // reservation starts with the fetch request
    instQueue #(
        .QueueDepth(QueueDepth)
    ) queue (
        .clk      (clk),
        .rst      (rst),
        .pushValid(pushValid),
        .pushItem (pushItem),
        .reserve  (fetchReq),
        .full     (queueFull),
        .instValid(instValid),
        .instItem (instItem),
        .instReady(instReady)
    );

endmodule

//--- tests/memSubsystemTb.sv
module memSubsystemTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memPkg::*;

    localparam int QueueDepth = 4;
    localparam int Timeout    = 200;

    logic      clk         = 1'b0;
    logic      rst         = 1'b1;
    logic      rdy         = 1'b1;
    logic      fetchEnable = 1'b0;
    logic      dataReq     = 1'b0;
    memReqT    dataCmd     = '0;
    logic      dataDone;
    wordT      dataRdata;
    logic      instValid;
    fetchItemT instItem;
    logic      instReady   = 1'b0;

    integer      seed      = 89230;
    logic        randomRdy = 1'b0;
    logic        aborted   = 1'b0;
    int          errors    = 0;
    int          passed    = 0;
    int          failed    = 0;
    int          curTest   = -1;
    int          fd;
    int          got;
    int          testNum;
    int          cycles;
    logic [7:0]  op;
    logic [31:0] arg1;
    logic [31:0] arg2;
    logic [31:0] arg3;

    memSubsystem #(.QueueDepth(QueueDepth)) uut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // about one stall cycle in four
    always @(posedge clk) begin
        if (randomRdy) begin
            rdy <= ($random(seed) & 3) != 0;
        end
    end

    task dataAccess(input logic isStore, input addrT addr, input lenT len, input wordT value);
        @(posedge clk);
        dataReq         <= 1'b1;
        dataCmd.isStore <= isStore;
        dataCmd.len     <= len;
        dataCmd.addr    <= addr;
        dataCmd.wdata   <= isStore ? value : '0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dataDone && cycles < Timeout);
        if (!dataDone) begin
            $display("timeout: %s at %h never saw dataDone", isStore ? "store" : "load", addr);
            aborted = 1'b1;
            errors++;
        end else if (!isStore && dataRdata !== value) begin
            $display("** Error at %0t: load %h expected %h, got %h", $time, addr, value,
                     dataRdata);
            errors++;
        end
        @(posedge clk);
        dataReq <= 1'b0;
    endtask

    task popItem(input addrT pc, input wordT inst);
        cycles = 0;
        @(negedge clk);
        while (!instValid && cycles < Timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (!instValid) begin
            $display("timeout: no instruction arrived for pop of pc %h", pc);
            aborted = 1'b1;
            errors++;
        end else begin
            if (instItem.pc !== pc || instItem.inst !== inst) begin
                $display("** Error at %0t: pop expected pc %h inst %h, got pc %h inst %h",
                         $time, pc, inst, instItem.pc, instItem.inst);
                errors++;
            end
            // pop lands on the second edge
            @(posedge clk);
            instReady <= 1'b1;
            @(posedge clk);
            instReady <= 1'b0;
        end
    endtask

    task closeTest();
        if (errors == 0) begin
            $display("test %0d passed", curTest);
            passed++;
        end else begin
            $display("test %0d failed with %0d errors", curTest, errors);
            failed++;
        end
        errors = 0;
    endtask

    initial begin
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("tests/memVectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/memVectors.txt");
            aborted = 1'b1;
        end
        // one op per line with test number, opcode and hex operands
        // S/L addr len data, P pc inst, W hold cycles, F fetch on, R reset with stalls
        while (!aborted && $fscanf(fd, "%d %c", testNum, op) == 2) begin
            if (curTest >= 0 && testNum != curTest) begin
                closeTest();
            end
            curTest = testNum;
            case (op)
                "S", "L": begin
                    got = $fscanf(fd, "%h %h %h", arg1, arg2, arg3);
                    if (got != 3) begin
                        $display("vector line %c of test %0d lacks operands", op, testNum);
                        aborted = 1'b1;
                        errors++;
                    end else begin
                        dataAccess(op == "S", arg1, arg2[2:0], arg3);
                    end
                end
                "P": begin
                    got = $fscanf(fd, "%h %h", arg1, arg2);
                    if (got != 2) begin
                        $display("vector line %c of test %0d lacks operands", op, testNum);
                        aborted = 1'b1;
                        errors++;
                    end else begin
                        popItem(arg1, arg2);
                    end
                end
                "F": begin
                    @(posedge clk);
                    fetchEnable <= 1'b1;
                end
                "W": begin
                    got = $fscanf(fd, "%d", arg1);
                    if (got != 1) begin
                        $display("vector line %c of test %0d lacks operands", op, testNum);
                        aborted = 1'b1;
                        errors++;
                    end else begin
                        repeat (arg1) begin
                            @(negedge clk);
                            if (uut.queue.count > QueueDepth) begin
                                $display("** Error at %0t: queue holds %0d items", $time,
                                         uut.queue.count);
                                errors++;
                            end
                        end
                    end
                end
                // back through reset so fetch starts over at pc 0
                "R": begin
                    @(posedge clk);
                    fetchEnable <= 1'b0;
                    rst         <= 1'b1;
                    repeat (3) @(posedge clk);
                    rst       <= 1'b0;
                    randomRdy <= 1'b1;
                end
                default: begin
                    $display("unknown opcode %c in test %0d", op, testNum);
                    errors++;
                end
            endcase
        end
        if (curTest >= 0) begin
            closeTest();
        end
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && passed > 0 && !aborted) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tests/memVectors.txt
1 S 00000100 1 000000a5
1 L 00000100 1 000000a5
1 S 00000104 2 0000beef
1 L 00000104 2 0000beef
1 S 00000108 4 12345678
1 L 0000010a 2 00001234
2 S 0000010b 1 000000ff
2 S 00000108 2 0000cafe
2 L 00000108 4 ff34cafe
3 S 00000000 4 00000013
3 S 00000004 4 00100093
3 S 00000008 4 00200113
3 S 0000000c 4 00300193
3 S 00000010 4 00400213
3 S 00000014 4 00500293
3 F
3 P 00000000 00000013
4 W 40
4 P 00000004 00100093
4 P 00000008 00200113
4 P 0000000c 00300193
4 P 00000010 00400213
5 S 00000110 4 a1b2c3d4
5 L 00000110 4 a1b2c3d4
5 P 00000014 00500293
6 R
6 S 00000100 1 000000a5
6 L 00000100 1 000000a5
6 S 00000108 4 12345678
6 L 0000010a 2 00001234
6 F
6 P 00000000 00000013
6 P 00000004 00100093
